// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    parameter int BYTE_LEN       = 8;
    parameter int WORD_WIDTH     = 32;
    parameter int WORDS_PER_LINE = 4;
    parameter int LINE_WIDTH     = WORD_WIDTH * WORDS_PER_LINE;
    parameter int ADDR_WIDTH     = 16;

    // byte lanes per word and per line
    parameter int WORD_MASK_LEN  = WORD_WIDTH / BYTE_LEN;
    parameter int LINE_MASK_LEN  = LINE_WIDTH / BYTE_LEN;

    // address split below the index field
    parameter int BYTE_OFF_WIDTH = $clog2(WORD_MASK_LEN);
    parameter int WORD_SEL_WIDTH = $clog2(WORDS_PER_LINE);
    parameter int OFFSET_WIDTH   = BYTE_OFF_WIDTH + WORD_SEL_WIDTH;

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_LOOKUP,      // tag and data RAM read
        ST_COMPARE,     // RAM outputs valid here
        ST_REFILL,      // one memory read per beat
        ST_FILL,        // write assembled line and tag
        ST_MEM_WRITE,   // write-through word
        ST_RESPOND
    } ctrl_state_t;

    typedef enum logic
    {
        OP_READ,
        OP_WRITE
    } core_op_t;

endpackage

`default_nettype wire

// File: single_port_blockram.sv
`timescale 1ns/1ns
`default_nettype none

module single_port_blockram
#(
    parameter SINGLE_ENTRY_WIDTH_IN_BITS = 64,
    parameter NUM_SET                    = 64,
    parameter SET_PTR_WIDTH_IN_BITS      = $clog2(NUM_SET),
    parameter WRITE_MASK_LEN             = SINGLE_ENTRY_WIDTH_IN_BITS / dcache_pkg::BYTE_LEN,
    parameter WITH_VALID_REG_ARRAY       = "Yes"
)
(
    input  wire                                    clk_in,
    input  wire                                    reset_in,

    input  wire                                    access_en_in,
    input  wire [WRITE_MASK_LEN             - 1:0] write_en_in,
    input  wire [SET_PTR_WIDTH_IN_BITS      - 1:0] access_set_addr_in,

    input  wire [SINGLE_ENTRY_WIDTH_IN_BITS - 1:0] write_entry_in,
    output logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1:0] read_entry_out,
    output logic                                   read_valid_out
);

    localparam int LANE = dcache_pkg::BYTE_LEN;

    logic [SINGLE_ENTRY_WIDTH_IN_BITS - 1:0] blockram [NUM_SET];

    generate
        if (WITH_VALID_REG_ARRAY == "Yes")
        begin : g_valid
            logic [NUM_SET - 1:0] valid_array;

            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                begin
                    valid_array    <= '0;
                    read_valid_out <= 1'b0;
                end
                else
                begin
                    if (access_en_in && |write_en_in)
                        valid_array[access_set_addr_in] <= 1'b1;   // any write validates

                    // old bit, same cycle as the old entry
                    read_valid_out <= access_en_in && valid_array[access_set_addr_in];
                end
            end
        end
        else
        begin : g_no_valid
            // entry is good one cycle after any access
            always_ff @(posedge clk_in or posedge reset_in)
            begin
                if (reset_in)
                    read_valid_out <= 1'b0;
                else
                    read_valid_out <= access_en_in;
            end
        end
    endgenerate

    always_ff @(posedge clk_in)
    begin
        if (access_en_in)
        begin
            for (int lane = 0; lane < WRITE_MASK_LEN; lane++)
            begin
                if (write_en_in[lane])
                    blockram[access_set_addr_in][lane * LANE +: LANE] <=
                        write_entry_in[lane * LANE +: LANE];
            end

            read_entry_out <= blockram[access_set_addr_in];   // read before write
        end
    end

endmodule

`default_nettype wire

// File: refill_counter.sv
`timescale 1ns/1ns
`default_nettype none

module refill_counter
#(
    parameter int BEATS = 4
)
(
    input  wire                         clk_in,
    input  wire                         reset_in,

    input  wire                         start,
    input  wire                         beat_done,
    output logic [$clog2(BEATS) - 1:0]  beat_index,
    output logic                        last_beat
);

    localparam int IDX_WIDTH = $clog2(BEATS);

    logic [IDX_WIDTH - 1:0] count;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
            count <= '0;
        else if (start)
            count <= '0;
        else if (beat_done)
            count <= count + 1'b1;   // wraps back to 0 after the last beat
    end

    assign beat_index = count;
    assign last_beat  = (count == IDX_WIDTH'(BEATS - 1));

endmodule

`default_nettype wire

// File: refill_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module refill_buffer
(
    input  wire                                     clk_in,
    input  wire                                     reset_in,

    input  wire                                     capture,
    input  wire [dcache_pkg::WORD_SEL_WIDTH - 1:0]  beat_index,
    input  wire [dcache_pkg::WORD_WIDTH     - 1:0]  mem_rdata,

    input  wire [dcache_pkg::WORD_WIDTH     - 1:0]  core_wdata,
    input  wire [dcache_pkg::WORD_SEL_WIDTH - 1:0]  word_sel,
    input  wire                                     fill_mode,

    output logic [dcache_pkg::LINE_WIDTH    - 1:0]  line_out,
    output logic [dcache_pkg::WORD_WIDTH    - 1:0]  word_out
);

    localparam int WW = dcache_pkg::WORD_WIDTH;

    logic [dcache_pkg::LINE_WIDTH - 1:0] line_q;

    // memory beats land in their own word slot
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
            line_q <= '0;
        else if (capture)
            line_q[beat_index * WW +: WW] <= mem_rdata;
    end

    // on a write hit the RAM lane mask picks one of the copies
    assign line_out = fill_mode ? line_q : {dcache_pkg::WORDS_PER_LINE{core_wdata}};

    assign word_out = line_q[word_sel * WW +: WW];   // read miss answer

endmodule

`default_nettype wire

// File: cache_controller.sv
`timescale 1ns/1ns
`default_nettype none

module cache_controller
#(
    parameter int NUM_SET   = 16,
    parameter int IDX_WIDTH = $clog2(NUM_SET),
    parameter int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - dcache_pkg::OFFSET_WIDTH - IDX_WIDTH
)
(
    input  wire                                       clk_in,
    input  wire                                       reset_in,

    input  wire                                       core_req,
    input  var dcache_pkg::core_op_t                  core_op,
    input  wire  [dcache_pkg::ADDR_WIDTH      - 1:0]  core_addr,
    input  wire  [dcache_pkg::WORD_WIDTH      - 1:0]  core_wdata,
    input  wire  [dcache_pkg::WORD_MASK_LEN   - 1:0]  core_wmask,
    output logic                                      core_ack,
    output logic [dcache_pkg::WORD_WIDTH      - 1:0]  core_rdata,
    output logic                                      core_hit,

    output logic                                      mem_req,
    output logic                                      mem_we,
    output logic [dcache_pkg::ADDR_WIDTH      - 1:0]  mem_addr,
    output logic [dcache_pkg::WORD_WIDTH      - 1:0]  mem_wdata,
    output logic [dcache_pkg::WORD_MASK_LEN   - 1:0]  mem_wmask,
    input  wire                                       mem_ack,

    output logic                                      tag_access,
    output logic [TAG_WIDTH / dcache_pkg::BYTE_LEN - 1:0] tag_we,
    output logic [TAG_WIDTH                   - 1:0]  tag_wdata,
    output logic                                      data_access,
    output logic [dcache_pkg::LINE_MASK_LEN   - 1:0]  data_we,
    output logic [IDX_WIDTH                   - 1:0]  set_addr,
    input  wire  [TAG_WIDTH                   - 1:0]  tag_rdata,
    input  wire                                       tag_valid,
    input  wire  [dcache_pkg::LINE_WIDTH      - 1:0]  line_rdata,

    input  wire  [dcache_pkg::WORD_SEL_WIDTH  - 1:0]  beat_index,
    input  wire                                       last_beat,
    output logic                                      refill_start,
    output logic                                      beat_done,
    output logic                                      capture,
    output logic                                      fill_mode,
    output logic [dcache_pkg::WORD_SEL_WIDTH  - 1:0]  word_sel,
    input  wire  [dcache_pkg::WORD_WIDTH      - 1:0]  buffer_word
);

    localparam int WW  = dcache_pkg::WORD_WIDTH;
    localparam int OFF = dcache_pkg::OFFSET_WIDTH;
    localparam int BO  = dcache_pkg::BYTE_OFF_WIDTH;

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::core_op_t    req_op;

    logic [dcache_pkg::ADDR_WIDTH    - 1:0] req_addr;
    logic [WW                        - 1:0] req_wdata;
    logic [dcache_pkg::WORD_MASK_LEN - 1:0] req_wmask;
    logic [TAG_WIDTH                 - 1:0] req_tag;
    logic [dcache_pkg::WORD_SEL_WIDTH - 1:0] req_word;
    logic hit;
    logic hit_q;
    logic is_write;
    logic write_hit;
    logic mem_done;

    assign req_tag   = req_addr[dcache_pkg::ADDR_WIDTH - 1 -: TAG_WIDTH];
    assign set_addr  = req_addr[OFF +: IDX_WIDTH];
    assign req_word  = req_addr[BO +: dcache_pkg::WORD_SEL_WIDTH];
    assign is_write  = (req_op == dcache_pkg::OP_WRITE);
    assign hit       = tag_valid && (tag_rdata == req_tag);   // RAM outputs valid in ST_COMPARE
    assign write_hit = (state == dcache_pkg::ST_COMPARE) && is_write && hit;
    assign mem_done  = mem_req && mem_ack;

    // request held for the whole transaction
    always_ff @(posedge clk_in)
    begin
        if (state == dcache_pkg::ST_IDLE && core_req)
        begin
            req_op    <= core_op;
            req_addr  <= core_addr;
            req_wdata <= core_wdata;
            req_wmask <= core_wmask;
        end
    end

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state    <= dcache_pkg::ST_IDLE;
            core_ack <= 1'b0;
            mem_req  <= 1'b0;
            mem_we   <= 1'b0;
            hit_q    <= 1'b0;
        end
        else
        begin
            case (state)
                dcache_pkg::ST_IDLE:
                    if (core_req)
                        state <= dcache_pkg::ST_LOOKUP;
                dcache_pkg::ST_LOOKUP:
                    state <= dcache_pkg::ST_COMPARE;
                dcache_pkg::ST_COMPARE:
                begin
                    hit_q <= hit;
                    if (is_write)
                        state <= dcache_pkg::ST_MEM_WRITE;   // write-through, hit or miss
                    else if (hit)
                        state <= dcache_pkg::ST_RESPOND;
                    else
                        state <= dcache_pkg::ST_REFILL;
                end
                dcache_pkg::ST_REFILL:
                    if (!mem_req && !mem_ack)
                        mem_req <= 1'b1;   // next beat only once ack is low
                    else if (mem_done)
                    begin
                        mem_req <= 1'b0;
                        if (last_beat)
                            state <= dcache_pkg::ST_FILL;
                    end
                dcache_pkg::ST_FILL:
                    state <= dcache_pkg::ST_RESPOND;
                dcache_pkg::ST_MEM_WRITE:
                    if (!mem_req && !mem_ack)
                    begin
                        mem_req <= 1'b1;
                        mem_we  <= 1'b1;
                    end
                    else if (mem_done)
                    begin
                        mem_req <= 1'b0;
                        mem_we  <= 1'b0;
                        state   <= dcache_pkg::ST_RESPOND;
                    end
                dcache_pkg::ST_RESPOND:
                    if (!core_ack)
                        core_ack <= 1'b1;
                    else if (!core_req)
                    begin
                        core_ack <= 1'b0;
                        state    <= dcache_pkg::ST_IDLE;
                    end
                default:
                    state <= dcache_pkg::ST_IDLE;
            endcase
        end
    end

    assign refill_start = (state == dcache_pkg::ST_COMPARE) && !is_write && !hit;
    assign beat_done    = (state == dcache_pkg::ST_REFILL) && mem_done;
    assign capture      = beat_done;   // buffer takes the word on the same edge
    assign fill_mode    = (state == dcache_pkg::ST_FILL);
    assign word_sel     = req_word;

    assign tag_access  = (state == dcache_pkg::ST_LOOKUP) || fill_mode;
    assign tag_we      = fill_mode ? '1 : '0;
    assign tag_wdata   = req_tag;
    assign data_access = (state == dcache_pkg::ST_LOOKUP) || fill_mode || write_hit;
    assign data_we     = fill_mode ? '1 :
                         write_hit ? (dcache_pkg::LINE_MASK_LEN'(req_wmask)
                                      << (req_word * dcache_pkg::WORD_MASK_LEN)) : '0;

    // refill walks the aligned line, writes go to the word itself
    assign mem_addr  = (state == dcache_pkg::ST_REFILL) ?
                       {req_addr[dcache_pkg::ADDR_WIDTH - 1:OFF], beat_index, BO'(0)} :
                       {req_addr[dcache_pkg::ADDR_WIDTH - 1:BO], BO'(0)};
    assign mem_wdata = req_wdata;
    assign mem_wmask = req_wmask;

    assign core_hit   = hit_q;
    assign core_rdata = hit_q ? line_rdata[req_word * WW +: WW] : buffer_word;

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top
#(
    parameter int NUM_SET = 16
)
(
    input  wire                                     clk_in,
    input  wire                                     reset_in,

    input  wire                                     core_req,
    input  var dcache_pkg::core_op_t                core_op,
    input  wire  [dcache_pkg::ADDR_WIDTH    - 1:0]  core_addr,
    input  wire  [dcache_pkg::WORD_WIDTH    - 1:0]  core_wdata,
    input  wire  [dcache_pkg::WORD_MASK_LEN - 1:0]  core_wmask,
    output logic                                    core_ack,
    output logic [dcache_pkg::WORD_WIDTH    - 1:0]  core_rdata,
    output logic                                    core_hit,

    output logic                                    mem_req,
    output logic                                    mem_we,
    output logic [dcache_pkg::ADDR_WIDTH    - 1:0]  mem_addr,
    output logic [dcache_pkg::WORD_WIDTH    - 1:0]  mem_wdata,
    output logic [dcache_pkg::WORD_MASK_LEN - 1:0]  mem_wmask,
    input  wire                                     mem_ack,
    input  wire  [dcache_pkg::WORD_WIDTH    - 1:0]  mem_rdata
);

    localparam int IDX_WIDTH = $clog2(NUM_SET);
    localparam int TAG_WIDTH = dcache_pkg::ADDR_WIDTH - dcache_pkg::OFFSET_WIDTH - IDX_WIDTH;
    localparam int TAG_LANES = TAG_WIDTH / dcache_pkg::BYTE_LEN;   // one lane at 16 sets

    logic                                     tag_access;
    logic [TAG_LANES                   - 1:0] tag_we;
    logic [TAG_WIDTH                   - 1:0] tag_wdata;
    logic [TAG_WIDTH                   - 1:0] tag_rdata;
    logic                                     tag_valid;
    logic                                     data_access;
    logic [dcache_pkg::LINE_MASK_LEN   - 1:0] data_we;
    logic [dcache_pkg::LINE_WIDTH      - 1:0] line_wdata;
    logic [dcache_pkg::LINE_WIDTH      - 1:0] line_rdata;
    logic [IDX_WIDTH                   - 1:0] set_addr;
    logic [dcache_pkg::WORD_SEL_WIDTH  - 1:0] beat_index;
    logic [dcache_pkg::WORD_SEL_WIDTH  - 1:0] word_sel;
    logic [dcache_pkg::WORD_WIDTH      - 1:0] buffer_word;
    logic last_beat;
    logic refill_start;
    logic beat_done;
    logic capture;
    logic fill_mode;

    cache_controller #(.NUM_SET(NUM_SET)) controller
    (
        .clk_in, .reset_in,
        .core_req, .core_op, .core_addr, .core_wdata, .core_wmask,
        .core_ack, .core_rdata, .core_hit,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_wmask, .mem_ack,
        .tag_access, .tag_we, .tag_wdata, .data_access, .data_we, .set_addr,
        .tag_rdata, .tag_valid, .line_rdata,
        .beat_index, .last_beat, .refill_start, .beat_done,
        .capture, .fill_mode, .word_sel, .buffer_word
    );

    refill_counter #(.BEATS(dcache_pkg::WORDS_PER_LINE)) counter
    (
        .clk_in, .reset_in,
        .start(refill_start), .beat_done, .beat_index, .last_beat
    );

    refill_buffer buffer
    (
        .clk_in, .reset_in,
        .capture, .beat_index, .mem_rdata, .core_wdata, .word_sel, .fill_mode,
        .line_out(line_wdata), .word_out(buffer_word)
    );

    single_port_blockram
    #(
        .SINGLE_ENTRY_WIDTH_IN_BITS(TAG_WIDTH),
        .NUM_SET(NUM_SET),
        .WITH_VALID_REG_ARRAY("Yes")
    ) tag_ram
    (
        .clk_in, .reset_in,
        .access_en_in(tag_access), .write_en_in(tag_we), .access_set_addr_in(set_addr),
        .write_entry_in(tag_wdata), .read_entry_out(tag_rdata), .read_valid_out(tag_valid)
    );

    single_port_blockram
    #(
        .SINGLE_ENTRY_WIDTH_IN_BITS(dcache_pkg::LINE_WIDTH),
        .NUM_SET(NUM_SET),
        .WITH_VALID_REG_ARRAY("No")
    ) data_ram
    (
        .clk_in, .reset_in,
        .access_en_in(data_access), .write_en_in(data_we), .access_set_addr_in(set_addr),
        .write_entry_in(line_wdata), .read_entry_out(line_rdata), .read_valid_out()
    );

endmodule

`default_nettype wire

// File: tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;

    localparam int NUM_SET        = 16;
    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_CYCLES = 200;
    localparam logic [31:0] SEED  = 32'h7f34a0c5;

    localparam int AW        = dcache_pkg::ADDR_WIDTH;
    localparam int WW        = dcache_pkg::WORD_WIDTH;
    localparam int ML        = dcache_pkg::WORD_MASK_LEN;
    localparam int BL        = dcache_pkg::BYTE_LEN;
    localparam int BO        = dcache_pkg::BYTE_OFF_WIDTH;
    localparam int OFF       = dcache_pkg::OFFSET_WIDTH;
    localparam int IDX_W     = $clog2(NUM_SET);
    localparam int TAG_W     = AW - OFF - IDX_W;
    localparam int MEM_WORDS = 2 ** (AW - BO);

    logic                  clk_in;
    logic                  reset_in;
    logic                  core_req;
    dcache_pkg::core_op_t  core_op;
    logic [AW - 1:0]       core_addr;
    logic [WW - 1:0]       core_wdata;
    logic [ML - 1:0]       core_wmask;
    logic                  core_ack;
    logic [WW - 1:0]       core_rdata;
    logic                  core_hit;
    logic                  mem_req;
    logic                  mem_we;
    logic [AW - 1:0]       mem_addr;
    logic [WW - 1:0]       mem_wdata;
    logic [ML - 1:0]       mem_wmask;
    logic                  mem_ack;
    logic [WW - 1:0]       mem_rdata;

    logic [WW - 1:0]    mem_model [MEM_WORDS];   // what the responder serves
    logic [WW - 1:0]    ref_mem   [MEM_WORDS];   // what the core should see
    logic [TAG_W - 1:0] ref_tag   [NUM_SET];
    logic               ref_valid [NUM_SET];

    int              rd_count;
    int              wr_count;
    int              bad_addr;
    logic [AW - 1:0] cur_addr;
    logic [WW - 1:0] last_wr_data;
    logic [ML - 1:0] last_wr_mask;
    int              op_num;
    int              data_errors;
    int              hit_errors;
    int              count_errors;
    int              other_errors;
    int              timeouts;

    dcache_top #(.NUM_SET(NUM_SET)) UUT
    (
        .clk_in, .reset_in,
        .core_req, .core_op, .core_addr, .core_wdata, .core_wmask,
        .core_ack, .core_rdata, .core_hit,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_wmask, .mem_ack, .mem_rdata
    );

    initial
    begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    // spreads values over every address bit
    function automatic logic [WW - 1:0] fill_word(input int unsigned idx);
        return (32'(idx) * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
    endfunction

    task automatic check_word(input string name, input logic [WW - 1:0] got,
                              input logic [WW - 1:0] exp);
        if (got !== exp)
        begin
            data_errors++;
            $display("mismatch %s op %0d: got 0x%h expected 0x%h", name, op_num, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input logic [ML - 1:0] got,
                              input logic [ML - 1:0] exp);
        if (got !== exp)
        begin
            data_errors++;
            $display("mismatch %s op %0d: got 0x%h expected 0x%h", name, op_num, got, exp);
        end
    endtask

    task automatic check_hit(input logic got, input logic exp);
        if (got !== exp)
        begin
            hit_errors++;
            $display("mismatch core_hit op %0d: got 0x%h expected 0x%h", op_num, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            count_errors++;
            $display("mismatch %s op %0d: got 0x%0h expected 0x%0h", name, op_num, got, exp);
        end
    endtask

    task automatic report_stall(input string what);
        timeouts++;
        if (mem_req)
            $display("timeout on op %0d: memory handshake stalled while waiting for %s",
                     op_num, what);
        else
            $display("timeout on op %0d: core handshake stalled while waiting for %s",
                     op_num, what);
    endtask

    task automatic wait_core_ack(input logic level, output bit ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ok && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk_in);
            ok = (core_ack === level);
            cycles++;
        end
        if (!ok)
            report_stall(level ? "core_ack to rise" : "core_ack to fall");
    endtask

    // memory responder answers one word per four-phase transaction
    initial
    begin : mem_responder
        int unsigned delay;
        int unsigned widx;
        delay     = $urandom(SEED);   // seeds the ack delay sequence
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever
        begin
            @(negedge clk_in);
            if (mem_req && !mem_ack)
            begin
                delay = $urandom_range(5, 0);
                repeat (delay) @(negedge clk_in);
                widx = mem_addr[AW - 1:BO];
                if (mem_we)
                begin
                    for (int b = 0; b < ML; b++)
                        if (mem_wmask[b])
                            mem_model[widx][b * BL +: BL] = mem_wdata[b * BL +: BL];
                    wr_count++;
                    last_wr_data = mem_wdata;
                    last_wr_mask = mem_wmask;
                    if (mem_addr != {cur_addr[AW - 1:BO], BO'(0)})
                        bad_addr++;
                end
                else
                begin
                    mem_rdata = mem_model[widx];
                    rd_count++;
                    if (mem_addr[AW - 1:OFF] != cur_addr[AW - 1:OFF] || mem_addr[BO - 1:0] != 0)
                        bad_addr++;   // outside the aligned line
                end
                mem_ack = 1'b1;
            end
            else if (!mem_req && mem_ack)
                mem_ack = 1'b0;
        end
    end

    initial
    begin
        int              fd;
        int              rc;
        int              op_val;
        int              hit_val;
        logic [AW - 1:0] addr_val;
        logic [WW - 1:0] wdata_val;
        logic [ML - 1:0] mask_val;
        string           line;
        bit              ok;
        bit              aborted;
        bit              model_hit;
        int              word_idx;
        int              set_idx;
        int              exp_rd;
        int              exp_wr;
        logic [TAG_W - 1:0] tag_val;

        data_errors  = 0;
        hit_errors   = 0;
        count_errors = 0;
        other_errors = 0;
        timeouts     = 0;
        op_num       = 0;
        rd_count     = 0;
        wr_count     = 0;
        bad_addr     = 0;
        cur_addr     = '0;
        last_wr_data = '0;
        last_wr_mask = '0;
        reset_in     = 1'b1;
        core_req     = 1'b0;
        core_op      = dcache_pkg::OP_READ;
        core_addr    = '0;
        core_wdata   = '0;
        core_wmask   = '0;
        aborted      = 1'b0;

        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem_model[i] = fill_word(i);
            ref_mem[i]   = fill_word(i);
        end
        for (int s = 0; s < NUM_SET; s++)
        begin
            ref_tag[s]   = '0;
            ref_valid[s] = 1'b0;
        end

        repeat (5) @(posedge clk_in);
        @(negedge clk_in);
        reset_in = 1'b0;

        fd = $fopen("dcache_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open dcache_stimulus.txt");
            other_errors++;
            aborted = 1'b1;
        end

        while (!aborted && !$feof(fd))
        begin
            rc = $fgets(line, fd);
            if (rc == 0 || line.len() < 2 || line.getc(0) == "#")
                continue;
            rc = $sscanf(line, "%h %h %h %h %h", op_val, addr_val, wdata_val, mask_val, hit_val);
            if (rc != 5)
                continue;
            op_num++;

            // reference model of a direct-mapped write-through cache without write allocate
            word_idx  = addr_val[AW - 1:BO];
            set_idx   = addr_val[OFF +: IDX_W];
            tag_val   = addr_val[AW - 1 -: TAG_W];
            model_hit = ref_valid[set_idx] && (ref_tag[set_idx] == tag_val);
            if (model_hit != hit_val[0])
            begin
                $display("stimulus op %0d expects hit %0d but the reference model predicts %0d",
                         op_num, hit_val[0], model_hit);
                other_errors++;
            end
            exp_rd = (op_val == 0 && !model_hit) ? dcache_pkg::WORDS_PER_LINE : 0;
            exp_wr = (op_val != 0) ? 1 : 0;
            if (op_val != 0)
            begin
                for (int b = 0; b < ML; b++)
                    if (mask_val[b])
                        ref_mem[word_idx][b * BL +: BL] = wdata_val[b * BL +: BL];
            end
            else if (!model_hit)
            begin
                ref_tag[set_idx]   = tag_val;   // refill installs the line
                ref_valid[set_idx] = 1'b1;
            end

            @(negedge clk_in);
            rd_count   = 0;
            wr_count   = 0;
            bad_addr   = 0;
            cur_addr   = addr_val;
            core_op    = (op_val != 0) ? dcache_pkg::OP_WRITE : dcache_pkg::OP_READ;
            core_addr  = addr_val;
            core_wdata = wdata_val;
            core_wmask = mask_val;
            core_req   = 1'b1;

            wait_core_ack(1'b1, ok);
            if (!ok)
            begin
                aborted = 1'b1;
                continue;
            end

            check_hit(core_hit, hit_val[0]);
            if (op_val == 0)
                check_word("core_rdata", core_rdata, ref_mem[word_idx]);
            check_count("memory reads", rd_count, exp_rd);
            check_count("memory writes", wr_count, exp_wr);
            check_count("mem_addr outside request", bad_addr, 0);
            if (op_val != 0)
            begin
                check_word("mem_wdata", last_wr_data, wdata_val);
                check_mask("mem_wmask", last_wr_mask, mask_val);
            end

            core_req = 1'b0;
            wait_core_ack(1'b0, ok);
            if (!ok)
                aborted = 1'b1;
        end
        if (fd != 0)
            $fclose(fd);

        if (op_num == 0)
        begin
            $display("no operations were read from the stimulus file");
            other_errors++;
        end

        repeat (2) @(negedge clk_in);
        $display("error counts: data %0d, hit %0d, count %0d, other %0d, timeout %0d",
                 data_errors, hit_errors, count_errors, other_errors, timeouts);
        if (data_errors + hit_errors + count_errors + other_errors + timeouts == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache_stimulus.txt
# op (0 read, 1 write), byte address, write data, byte mask, expected hit
# all columns hex, one core operation per line
0 0104 00000000 0 0
0 0108 00000000 0 1
0 0100 00000000 0 1
0 010c 00000000 0 1
0 0214 00000000 0 0
0 0218 00000000 0 1
1 0108 deadbeef f 1
0 0108 00000000 0 1
1 010c 11223344 5 1
0 010c 00000000 0 1
1 0334 a5a5a5a5 3 0
0 0334 00000000 0 0
1 0504 cafef00d c 0
0 0104 00000000 0 1
0 0504 00000000 0 0
0 0104 00000000 0 0
0 0504 00000000 0 0
0 0104 00000000 0 0
0 0500 00000000 0 0
0 050c 00000000 0 1
1 0508 0badf00d 2 1
0 0508 00000000 0 1
0 fff0 00000000 0 0
0 fffc 00000000 0 1
0 0228 00000000 0 0
1 0220 12345678 8 1
0 0220 00000000 0 1
0 0218 00000000 0 1
0 0334 00000000 0 1

// File: dcache.f
dcache_pkg.sv
single_port_blockram.sv
refill_counter.sv
refill_buffer.sv
cache_controller.sv
dcache_top.sv
tb_dcache.sv

// File: run_sim.sh
#!/bin/sh
# build and run tb_dcache with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_dcache -f dcache.f -o tb_dcache \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_dcache > sim.log 2>&1 || { cat sim.log; echo "simulation did not complete"; exit 1; }

cat sim.log

grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
